// File: design/dma_check_top.sv
// dma exerciser top
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_check_top
    import dma_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    // host command port
    input  logic                   i_cmd_req,
    input  logic [1:0]             i_cmd_addr,
    input  cmd_word_u              i_cmd_data,
    output logic                   o_cmd_ack,
    // status
    output logic                   o_busy,
    output logic                   o_done,
    output logic                   o_err,
    output logic [`DMA_CNT_W-1:0]  o_word_count,
    output logic [`DMA_BCNT_W-1:0] o_byte_count
);

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    // seed bus, shared by both loads
    logic [`DMA_DW-1:0]   seed;
    logic                 src_load;
    logic                 chk_load;
    // fetch handshake
    logic                 fetch_req;
    logic                 fetch_ack;
    logic [`DMA_DW-1:0]   fetch_word;
    // deliver handshake
    logic                 dlv_req;
    logic                 dlv_ack;
    logic [`DMA_DW-1:0]   dlv_word;
    logic [`DMA_DW/8-1:0] dlv_mask;

    ////////////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////////////

    dma_control u_control (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_cmd_req   (i_cmd_req),
        .i_cmd_addr  (i_cmd_addr),
        .i_cmd_data  (i_cmd_data),
        .o_cmd_ack   (o_cmd_ack),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_seed      (seed),
        .o_src_load  (src_load),
        .o_chk_load  (chk_load),
        .o_fetch_req (fetch_req),
        .i_fetch_ack (fetch_ack),
        .i_word      (fetch_word),
        .o_dlv_req   (dlv_req),
        .o_dlv_word  (dlv_word),
        .o_dlv_mask  (dlv_mask),
        .i_dlv_ack   (dlv_ack)
    );

    // pattern generator
    pattern_source u_source (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_load      (src_load),
        .i_seed      (seed),
        .i_fetch_req (fetch_req),
        .o_fetch_ack (fetch_ack),
        .o_word      (fetch_word)
    );

    // compare and count
    pattern_checker u_checker (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_load       (chk_load),
        .i_seed       (seed),
        .i_dlv_req    (dlv_req),
        .i_dlv_word   (dlv_word),
        .i_dlv_mask   (dlv_mask),
        .o_dlv_ack    (dlv_ack),
        .o_err        (o_err),
        .o_word_count (o_word_count),
        .o_byte_count (o_byte_count)
    );

endmodule

// File: design/dma_control.sv
// dma exerciser control
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_control
    import dma_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_reset,
    // host command port
    input  logic                 i_cmd_req,
    input  logic [1:0]           i_cmd_addr,
    input  cmd_word_u            i_cmd_data,
    output logic                 o_cmd_ack,
    output logic                 o_busy,
    output logic                 o_done,
    // seed distribution
    output logic [`DMA_DW-1:0]   o_seed,
    output logic                 o_src_load,
    output logic                 o_chk_load,
    // fetch side
    output logic                 o_fetch_req,
    input  logic                 i_fetch_ack,
    input  logic [`DMA_DW-1:0]   i_word,
    // deliver side
    output logic                 o_dlv_req,
    output logic [`DMA_DW-1:0]   o_dlv_word,
    output logic [`DMA_DW/8-1:0] o_dlv_mask,
    input  logic                 i_dlv_ack
);

    ctl_state_e            state;
    cmd_word_u             cmd_q;
    logic [1:0]            addr_q;
    logic                  cmd_stb;
    logic [`DMA_CNT_W-1:0] remain;
    logic [`DMA_DW/8-1:0]  mask_q;
    logic [`DMA_DW-1:0]    word_q;
    logic                  wr_src;
    logic                  wr_chk;
    logic                  wr_start;

    ////////////////////////////////////////////////////////////
    // host port
    ////////////////////////////////////////////////////////////

    // ack tracks req one cycle late
    // cmd_stb marks the cycle after the ack rise
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_cmd_ack <= 1'b0;
            cmd_stb   <= 1'b0;
        end else begin
            o_cmd_ack <= i_cmd_req;
            cmd_stb   <= i_cmd_req && !o_cmd_ack;
        end
    end

    // command taken on the ack rising edge
    always_ff @(posedge i_clk) begin
        if (i_cmd_req && !o_cmd_ack) begin
            addr_q <= i_cmd_addr;
            cmd_q  <= i_cmd_data;
        end
    end

    // writes while busy are acked and dropped
    assign wr_src   = cmd_stb && !o_busy && (addr_q == `DMA_A_SRC_SEED);
    assign wr_chk   = cmd_stb && !o_busy && (addr_q == `DMA_A_CHK_SEED);
    assign wr_start = cmd_stb && !o_busy && (addr_q == `DMA_A_START);

    // same seed bus for both loads
    assign o_seed     = cmd_q.seed;
    assign o_src_load = wr_src;
    assign o_chk_load = wr_chk;

    ////////////////////////////////////////////////////////////
    // transfer sequencer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state  <= IDLE;
            o_busy <= 1'b0;
            o_done <= 1'b0;
            remain <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_start) begin
                        // zero length finishes at once
                        o_done <= 1'b1;
                        if (cmd_q.xfer.len != '0) begin
                            o_busy <= 1'b1;
                            o_done <= 1'b0;
                            remain <= cmd_q.xfer.len;
                            state  <= FETCH;
                        end
                    end
                end
                FETCH: begin
                    if (i_fetch_ack)
                        state <= FETCH_REL;
                end
                FETCH_REL: begin
                    if (!i_fetch_ack)
                        state <= DELIVER;
                end
                DELIVER: begin
                    if (i_dlv_ack) begin
                        remain <= remain - 1'b1;
                        state  <= DELIVER_REL;
                    end
                end
                DELIVER_REL: begin
                    // last word once the checker lets go
                    if (!i_dlv_ack) begin
                        if (remain == '0) begin
                            o_busy <= 1'b0;
                            o_done <= 1'b1;
                            state  <= IDLE;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // word and mask held for the deliver phase
    always_ff @(posedge i_clk) begin
        if (state == FETCH && i_fetch_ack)
            word_q <= i_word;
        if (wr_start)
            mask_q <= cmd_q.xfer.mask;
    end

    // req lines straight from state
    assign o_fetch_req = (state == FETCH);
    assign o_dlv_req   = (state == DELIVER);
    assign o_dlv_word  = word_q;
    assign o_dlv_mask  = mask_q;

endmodule

// File: design/dma_pkg.sv
// dma exerciser types
`include "dma_params.svh"

package dma_pkg;

    // transfer descriptor view of a command word
    typedef struct packed {
        logic [`DMA_DW-`DMA_CNT_W-`DMA_DW/8-1:0] rsvd;
        logic [`DMA_DW/8-1:0]                   mask;
        logic [`DMA_CNT_W-1:0]                  len;
    } xfer_desc_t;

    // one host word, read as a seed or as a descriptor
    typedef union packed {
        logic [`DMA_DW-1:0] seed;
        xfer_desc_t         xfer;
    } cmd_word_u;

    // transfer sequencer states
    typedef enum logic [2:0] {IDLE, FETCH, FETCH_REL, DELIVER, DELIVER_REL} ctl_state_e;

    // shift left, new lsb is bit 31 xor bit 30
    function automatic logic [`DMA_DW-1:0] lfsr_next(input logic [`DMA_DW-1:0] v);
        return {v[`DMA_DW-2:0], v[`DMA_DW-1] ^ v[`DMA_DW-2]};
    endfunction

endpackage

// File: design/pattern_checker.sv
// lfsr pattern checker
`timescale 1ns/1ps
`include "dma_params.svh"

module pattern_checker
    import dma_pkg::*;
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    // seed load, also clears status
    input  logic                   i_load,
    input  logic [`DMA_DW-1:0]     i_seed,
    // deliver handshake
    input  logic                   i_dlv_req,
    input  logic [`DMA_DW-1:0]     i_dlv_word,
    input  logic [`DMA_DW/8-1:0]   i_dlv_mask,
    output logic                   o_dlv_ack,
    // status
    output logic                   o_err,
    output logic [`DMA_CNT_W-1:0]  o_word_count,
    output logic [`DMA_BCNT_W-1:0] o_byte_count
);

    localparam int NB = `DMA_DW / 8;

    logic [`DMA_DW-1:0] expect_q;
    logic [NB-1:0]      lane_bad;
    logic [3:0]         n_bytes;
    logic               dlv_start;

    ////////////////////////////////////////////////////////////
    // lane compare
    ////////////////////////////////////////////////////////////

    // only enabled lanes can flag a miss
    always_comb begin
        for (int i = 0; i < NB; i++)
            lane_bad[i] = i_dlv_mask[i] && (i_dlv_word[i*8 +: 8] != expect_q[i*8 +: 8]);
    end

    // enabled byte count for this word
    always_comb begin
        n_bytes = '0;
        for (int i = 0; i < NB; i++)
            n_bytes = n_bytes + 4'(i_dlv_mask[i]);
    end

    // first cycle of req seen high
    assign dlv_start = i_dlv_req && !o_dlv_ack;

    ////////////////////////////////////////////////////////////
    // reference and status
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            expect_q     <= '0;
            o_dlv_ack    <= 1'b0;
            o_err        <= 1'b0;
            o_word_count <= '0;
            o_byte_count <= '0;
        end else if (i_load) begin
            // new seed restarts the check
            expect_q     <= i_seed;
            o_err        <= 1'b0;
            o_word_count <= '0;
            o_byte_count <= '0;
        end else if (dlv_start) begin
            // sticky error, counts on the req edge
            o_err        <= o_err || (|lane_bad);
            o_word_count <= o_word_count + 1'b1;
            o_byte_count <= o_byte_count + `DMA_BCNT_W'(n_bytes);
            o_dlv_ack    <= 1'b1;
        end else if (!i_dlv_req && o_dlv_ack) begin
            // release, then move to next expected word
            o_dlv_ack <= 1'b0;
            expect_q  <= lfsr_next(expect_q);
        end
    end

endmodule

// File: design/pattern_source.sv
// lfsr pattern source
`timescale 1ns/1ps
`include "dma_params.svh"

module pattern_source
    import dma_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_reset,
    // seed load
    input  logic               i_load,
    input  logic [`DMA_DW-1:0] i_seed,
    // fetch handshake
    input  logic               i_fetch_req,
    output logic               o_fetch_ack,
    output logic [`DMA_DW-1:0] o_word
);

    logic [`DMA_DW-1:0] lfsr;

    ////////////////////////////////////////////////////////////
    // generator state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            lfsr        <= '0;
            o_fetch_ack <= 1'b0;
        end else begin
            // seed only arrives while control is idle
            if (i_load)
                lfsr <= i_seed;

            if (i_fetch_req && !o_fetch_ack) begin
                // word already on o_word, just ack
                o_fetch_ack <= 1'b1;
            end else if (!i_fetch_req && o_fetch_ack) begin
                // handshake done, step to next word
                o_fetch_ack <= 1'b0;
                lfsr        <= lfsr_next(lfsr);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // word output
    ////////////////////////////////////////////////////////////

    // current value, held until ack drops
    // zero seed keeps this at zero forever
    assign o_word = lfsr;

endmodule

// File: dv/dma_check_monitor.sv
// dma exerciser result monitor
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_check_monitor (
    input  logic                   i_clk,
    input  logic                   i_reset,
    // compare request outside a done edge
    input  logic                   i_snap,
    // expected results from the testbench
    input  logic                   i_exp_err,
    input  logic [`DMA_CNT_W-1:0]  i_exp_words,
    input  logic [`DMA_BCNT_W-1:0] i_exp_bytes,
    input  logic                   i_exp_done,
    // dut ports
    input  logic                   i_cmd_ack,
    input  logic                   i_busy,
    input  logic                   i_done,
    input  logic                   i_err,
    input  logic [`DMA_CNT_W-1:0]  i_word_count,
    input  logic [`DMA_BCNT_W-1:0] i_byte_count,
    output int                     o_mismatches
);

    logic done_q;
    int   mismatches = 0;

    assign o_mismatches = mismatches;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, got %h", name, exp, act);
            mismatches++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare points
    ////////////////////////////////////////////////////////////

    // status is stable the cycle after done rises
    always @(posedge i_clk) begin
        if (i_reset) begin
            done_q <= 1'b0;
        end else begin
            done_q <= i_done;
            if (i_done && !done_q) begin
                compare("o_err", i_exp_err, i_err);
                compare("o_word_count", i_exp_words, i_word_count);
                compare("o_byte_count", i_exp_bytes, i_byte_count);
                compare("o_busy", 1'b0, i_busy);
            end
            // idle check, done level given by the testbench
            if (i_snap) begin
                compare("o_err", i_exp_err, i_err);
                compare("o_word_count", i_exp_words, i_word_count);
                compare("o_byte_count", i_exp_bytes, i_byte_count);
                compare("o_busy", 1'b0, i_busy);
                compare("o_done", i_exp_done, i_done);
                compare("o_cmd_ack", 1'b0, i_cmd_ack);
            end
        end
    end

endmodule

// File: dv/dma_check_props.sv
// dma control handshake assertions
`timescale 1ns/1ps

module dma_check_props
    import dma_pkg::*;
(
    input logic       i_clk,
    input logic       i_reset,
    input logic       i_cmd_req,
    input logic       i_cmd_ack,
    input logic       i_fetch_req,
    input logic       i_fetch_ack,
    input logic       i_dlv_req,
    input logic       i_dlv_ack,
    input logic       i_busy,
    input logic       i_done,
    input ctl_state_e i_state
);

    int assert_fails = 0;

    // host ack only follows a req
    assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_cmd_ack) |-> $past(i_cmd_req))
        else begin
            $error("cmd ack rose without cmd req");
            assert_fails++;
        end

    // internal reqs held until acked
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_fetch_req && !i_fetch_ack |=> i_fetch_req)
        else begin
            $error("fetch req dropped before ack");
            assert_fails++;
        end

    assert property (@(posedge i_clk) disable iff (i_reset)
        i_dlv_req && !i_dlv_ack |=> i_dlv_req)
        else begin
            $error("deliver req dropped before ack");
            assert_fails++;
        end

    // source and checker fully released while idle
    assert property (@(posedge i_clk) disable iff (i_reset)
        i_state == IDLE |-> !i_fetch_ack && !i_dlv_ack)
        else begin
            $error("datapath ack high while sequencer idle");
            assert_fails++;
        end

    assert property (@(posedge i_clk) disable iff (i_reset) !(i_busy && i_done))
        else begin
            $error("busy and done high together");
            assert_fails++;
        end

endmodule

bind dma_control dma_check_props u_props (
    .i_clk(i_clk), .i_reset(i_reset), .i_cmd_req(i_cmd_req), .i_cmd_ack(o_cmd_ack),
    .i_fetch_req(o_fetch_req), .i_fetch_ack(i_fetch_ack), .i_dlv_req(o_dlv_req),
    .i_dlv_ack(i_dlv_ack), .i_busy(o_busy), .i_done(o_done), .i_state(state)
);

// File: dv/dma_check_tb.sv
// dma exerciser testbench
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_check_tb
    import dma_pkg::*;
();

    // timing bounds, in clock cycles
    localparam int MAX_LEN      = 40;
    localparam int WORD_CYC     = 12;
    localparam int CMD_CYC      = 40;
    localparam int N_XFERS      = 14;
    localparam int DONE_LIMIT   = MAX_LEN * WORD_CYC + CMD_CYC;
    localparam int WATCHDOG_CYC = N_XFERS * DONE_LIMIT + 50;

    logic                   clk;
    logic                   reset;
    logic                   cmd_req;
    logic [1:0]             cmd_addr;
    cmd_word_u              cmd_data;
    logic                   cmd_ack;
    logic                   busy;
    logic                   done;
    logic                   err;
    logic [`DMA_CNT_W-1:0]  word_count;
    logic [`DMA_BCNT_W-1:0] byte_count;
    // expected results posted for the monitor
    logic                   exp_err;
    logic [`DMA_CNT_W-1:0]  exp_words;
    logic [`DMA_BCNT_W-1:0] exp_bytes;
    logic                   exp_done;
    logic                   snap;
    int                     mismatches;
    int                     hs_errors;
    logic [15:0]            rng;

    always #50 clk = ~clk;

    dma_check_top uut (
        .i_clk(clk), .i_reset(reset), .i_cmd_req(cmd_req), .i_cmd_addr(cmd_addr),
        .i_cmd_data(cmd_data), .o_cmd_ack(cmd_ack), .o_busy(busy), .o_done(done),
        .o_err(err), .o_word_count(word_count), .o_byte_count(byte_count)
    );

    dma_check_monitor u_monitor (
        .i_clk(clk), .i_reset(reset), .i_snap(snap), .i_exp_err(exp_err),
        .i_exp_words(exp_words), .i_exp_bytes(exp_bytes), .i_exp_done(exp_done),
        .i_cmd_ack(cmd_ack), .i_busy(busy), .i_done(done), .i_err(err),
        .i_word_count(word_count), .i_byte_count(byte_count), .o_mismatches(mismatches)
    );

    ////////////////////////////////////////////////////////////
    // random bits and reference model
    ////////////////////////////////////////////////////////////

    // 16-bit galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] galois_step(input logic [15:0] v);
        return v[0] ? ((v >> 1) ^ 16'hb400) : (v >> 1);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r   = {r[30:0], rng[0]};
            rng = galois_step(rng);
        end
        return r;
    endfunction

    // shift left, bit 0 gets bit 31 xor bit 30
    function automatic logic [31:0] pattern_step(input logic [31:0] v);
        return {v[30:0], v[31] ^ v[30]};
    endfunction

    // expected {err, words, bytes} for one transfer
    function automatic logic [`DMA_CNT_W+`DMA_BCNT_W:0] ref_result(
        input logic [31:0] src, input logic [31:0] chk, input int len, input logic [3:0] mask);
        logic [31:0]            s;
        logic [31:0]            c;
        logic                   e;
        logic [`DMA_CNT_W-1:0]  w;
        logic [`DMA_BCNT_W-1:0] b;
        s = src;
        c = chk;
        e = 1'b0;
        w = '0;
        b = '0;
        for (int i = 0; i < len; i++) begin
            for (int k = 0; k < 4; k++) begin
                if (mask[k]) begin
                    b = b + 1'b1;
                    if (s[k*8 +: 8] != c[k*8 +: 8])
                        e = 1'b1;
                end
            end
            w = w + 1'b1;
            s = pattern_step(s);
            c = pattern_step(c);
        end
        return {e, w, b};
    endfunction

    ////////////////////////////////////////////////////////////
    // host driver
    ////////////////////////////////////////////////////////////

    task automatic wait_cmd_ack(input logic level);
        int n;
        n = 0;
        while (cmd_ack !== level && n < CMD_CYC) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack !== level) begin
            $display("host handshake stalled, ack never went to %0d", level);
            hs_errors++;
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done !== 1'b1 && n < DONE_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done !== 1'b1) begin
            $display("transfer never finished, done stayed low");
            hs_errors++;
        end
    endtask

    // one four-phase command
    task automatic host_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        cmd_addr = addr;
        cmd_data = data;
        cmd_req  = 1'b1;
        wait_cmd_ack(1'b1);
        cmd_req = 1'b0;
        wait_cmd_ack(1'b0);
    endtask

    task automatic host_start(input int len, input logic [3:0] mask, input logic wait_end);
        cmd_word_u w;
        w           = '0;
        w.xfer.len  = len;
        w.xfer.mask = mask;
        host_write(`DMA_A_START, w);
        if (wait_end)
            wait_done();
    endtask

    task automatic post_expected(input logic [31:0] src, input logic [31:0] chk,
                                 input int len, input logic [3:0] mask);
        {exp_err, exp_words, exp_bytes} = ref_result(src, chk, len, mask);
        exp_done = 1'b1;
    endtask

    task automatic run_transfer(input logic [31:0] src, input logic [31:0] chk,
                                input int len, input logic [3:0] mask);
        host_write(`DMA_A_SRC_SEED, src);
        host_write(`DMA_A_CHK_SEED, chk);
        post_expected(src, chk, len, mask);
        host_start(len, mask, 1'b1);
    endtask

    // status compare outside a done edge, cleared counts expected
    task automatic snap_check(input logic done_level);
        @(negedge clk);
        {exp_err, exp_words, exp_bytes} = '0;
        exp_done = done_level;
        snap     = 1'b1;
        @(negedge clk);
        snap = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] s;
        logic [31:0] c;
        logic [3:0]  m;
        int          sel;
        int          a_fails;
        clk      = 1'b0;
        reset    = 1'b1;
        cmd_req  = 1'b0;
        cmd_addr = '0;
        cmd_data = '0;
        snap     = 1'b0;
        exp_err  = 1'b0;
        exp_words = '0;
        exp_bytes = '0;
        exp_done = 1'b0;
        hs_errors = 0;
        rng      = 16'd65;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // idle status straight out of reset
        snap_check(1'b0);
        // zero length start gives done and no data
        post_expected('0, '0, 0, 4'hf);
        host_start(0, 4'hf, 1'b1);

        // equal seeds, all lanes
        s = rand_bits(32);
        run_transfer(s, s, 1 + rand_bits(6) % MAX_LEN, 4'hf);
        // unrelated seeds, some lanes
        s = rand_bits(32);
        c = rand_bits(32);
        m = rand_bits(4);
        if (m == 4'h0)
            m = 4'b0110;
        run_transfer(s, c, 1 + rand_bits(6) % MAX_LEN, m);
        // top lane differs but is masked off
        s = rand_bits(32);
        run_transfer(s, s ^ 32'hff00_0000, 1 + rand_bits(6) % MAX_LEN, 4'b0111);
        run_transfer(s, ~s, 1 + rand_bits(6) % MAX_LEN, 4'h0);

        // sticky error, then a check reload clears it
        run_transfer(s, s ^ 32'h1, 8, 4'hf);
        host_write(`DMA_A_CHK_SEED, s);
        snap_check(1'b1);
        run_transfer(s, s, 6, 4'b1001);

        // writes during a transfer are dropped
        s = rand_bits(32);
        host_write(`DMA_A_SRC_SEED, s);
        host_write(`DMA_A_CHK_SEED, s);
        post_expected(s, s, 24, 4'b1011);
        host_start(24, 4'b1011, 1'b0);
        host_write(`DMA_A_SRC_SEED, ~s);
        host_write(`DMA_A_CHK_SEED, ~s);
        host_start(3, 4'hf, 1'b0);
        wait_done();

        // random mix: same seed, one lane flipped, or unrelated
        for (int t = 0; t < 5; t++) begin
            s   = rand_bits(32);
            sel = rand_bits(2);
            if (sel == 0)
                c = s;
            else if (sel == 1)
                c = s ^ (32'hff << (8 * rand_bits(2)));
            else
                c = rand_bits(32);
            run_transfer(s, c, 1 + rand_bits(6) % MAX_LEN, rand_bits(4));
        end

        repeat (3) @(negedge clk);
        a_fails = uut.u_control.u_props.assert_fails;
        $display("errors: mismatches %0d, handshake %0d, assertions %0d",
                 mismatches, hs_errors, a_fails);
        if (mismatches == 0 && hs_errors == 0 && a_fails == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // run length bound
    initial begin
        #(WATCHDOG_CYC * 100);
        $display("watchdog expired before the test sequence ended");
        $display("Something failed");
        $finish;
    end

endmodule

// File: include/dma_params.svh
// dma exerciser parameters
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// data path word, fixed at 32 bits
`define DMA_DW 32

// word count and transfer length
`define DMA_CNT_W 12

// enabled byte count, holds 4 x max length
`define DMA_BCNT_W 14

// host register map, 2-bit address
`define DMA_A_SRC_SEED 2'd0
`define DMA_A_CHK_SEED 2'd1
`define DMA_A_START 2'd2

`endif

// File: sim.f
+incdir+include
design/dma_pkg.sv
design/pattern_source.sv
design/pattern_checker.sv
design/dma_control.sv
design/dma_check_top.sv
dv/dma_check_monitor.sv
dv/dma_check_props.sv
dv/dma_check_tb.sv
